/* design/scalerPkg.sv */
package scalerPkg;

    localparam int AddrWidth = 6;
    localparam int AxiDataWidth = 32;

    // Register byte offsets
    localparam logic [AddrWidth-1:0] CtrlAddr    = 6'h00;
    localparam logic [AddrWidth-1:0] GainAddr    = 6'h04;
    localparam logic [AddrWidth-1:0] OffsetAddr  = 6'h08;
    localparam logic [AddrWidth-1:0] DataInAddr  = 6'h0C;
    localparam logic [AddrWidth-1:0] DataOutAddr = 6'h10;
    localparam logic [AddrWidth-1:0] StatusAddr  = 6'h14;

    // STATUS bit positions
    localparam int StatusInEmpty   = 0;
    localparam int StatusInFull    = 1;
    localparam int StatusOutEmpty  = 2;
    localparam int StatusOutFull   = 3;
    localparam int StatusOverflow  = 4;
    localparam int StatusUnderflow = 5;
    localparam int StatusCountLsb  = 8;  // Output FIFO count field

    localparam logic [1:0] RespOkay   = 2'b00;
    localparam logic [1:0] RespSlvErr = 2'b10;

    localparam int GainFracBits = 8;  // Gain is unsigned 8.8

endpackage

/* design/sampleFifo.sv */
`timescale 1ns/1ps

module sampleFifo #(
    parameter int DataWidth = 16,
    parameter int DepthLog2 = 4
) (
    input  logic                 Clk,
    input  logic                 reset,
    input  logic                 Clear,
    input  logic                 Push,
    input  logic [DataWidth-1:0] PushData,
    input  logic                 Pop,
    output logic [DataWidth-1:0] PopData,
    output logic                 Full,
    output logic                 Empty,
    output logic [DepthLog2:0]   Count
);

    localparam int Depth = 2 ** DepthLog2;

    logic [DataWidth-1:0] mem [Depth];
    logic [DepthLog2:0]   wrPtr;  // MSB is the wrap bit
    logic [DepthLog2:0]   rdPtr;
    logic                 doPush;
    logic                 doPop;

    assign doPush = Push && !Full;
    assign doPop  = Pop && !Empty;

    always_ff @(posedge Clk) begin
        if (reset || Clear) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (doPush && !Clear) begin
            mem[wrPtr[DepthLog2-1:0]] <= PushData;
        end
        if (doPop && !Clear) begin
            PopData <= mem[rdPtr[DepthLog2-1:0]];  // Held until the next pop
        end
    end

    // Same index with opposite wrap bits means the buffer is full
    assign Full  = (wrPtr[DepthLog2] != rdPtr[DepthLog2]) &&
                   (wrPtr[DepthLog2-1:0] == rdPtr[DepthLog2-1:0]);
    assign Empty = (wrPtr == rdPtr);
    assign Count = wrPtr - rdPtr;

endmodule

/* design/axiLiteRegs.sv */
`timescale 1ns/1ps

module axiLiteRegs #(
    parameter int SampleWidth   = 16,
    parameter int FifoDepthLog2 = 4
) (
    input  logic                                  Clk,
    input  logic                                  reset,

    input  logic [scalerPkg::AddrWidth-1:0]       sAwAddr,
    input  logic                                  sAwValid,
    output logic                                  sAwReady,
    input  logic [scalerPkg::AxiDataWidth-1:0]    sWData,
    input  logic [scalerPkg::AxiDataWidth/8-1:0]  sWStrb,  // Full-word writes only
    input  logic                                  sWValid,
    output logic                                  sWReady,
    output logic [1:0]                            sBResp,
    output logic                                  sBValid,
    input  logic                                  sBReady,
    input  logic [scalerPkg::AddrWidth-1:0]       sArAddr,
    input  logic                                  sArValid,
    output logic                                  sArReady,
    output logic [scalerPkg::AxiDataWidth-1:0]    sRData,
    output logic [1:0]                            sRResp,
    output logic                                  sRValid,
    input  logic                                  sRReady,

    output logic                                  Clear,
    output logic [15:0]                           Gain,
    output logic [SampleWidth-1:0]                Offset,
    output logic                                  InPush,
    output logic [SampleWidth-1:0]                InPushData,
    input  logic                                  InFull,
    input  logic                                  InEmpty,
    output logic                                  OutPop,
    input  logic [SampleWidth-1:0]                OutPopData,
    input  logic                                  OutFull,
    input  logic                                  OutEmpty,
    input  logic [FifoDepthLog2:0]                OutCount
);

    localparam int DataW = scalerPkg::AxiDataWidth;
    localparam int ExtW  = DataW - SampleWidth;

    logic             writeFire;
    logic             readFire;
    logic             wrMapped;
    logic             rdMapped;
    logic             overflow;
    logic             underflow;
    logic             rdFromFifo;
    logic [DataW-1:0] rdDataReg;
    logic [DataW-1:0] rdValue;
    logic [DataW-1:0] status;

    // Address and data accepted together with one write in flight
    assign writeFire = sAwValid && sWValid && !sBValid;
    assign sAwReady  = writeFire;
    assign sWReady   = writeFire;

    assign sArReady = !sRValid;
    assign readFire = sArValid && sArReady;

    assign wrMapped = sAwAddr inside {scalerPkg::CtrlAddr, scalerPkg::GainAddr,
                                      scalerPkg::OffsetAddr, scalerPkg::DataInAddr,
                                      scalerPkg::DataOutAddr, scalerPkg::StatusAddr};
    assign rdMapped = sArAddr inside {scalerPkg::CtrlAddr, scalerPkg::GainAddr,
                                      scalerPkg::OffsetAddr, scalerPkg::DataInAddr,
                                      scalerPkg::DataOutAddr, scalerPkg::StatusAddr};

    assign Clear      = writeFire && (sAwAddr == scalerPkg::CtrlAddr) && sWData[0];
    assign InPush     = writeFire && (sAwAddr == scalerPkg::DataInAddr) && !InFull;
    assign InPushData = sWData[SampleWidth-1:0];
    assign OutPop     = readFire && (sArAddr == scalerPkg::DataOutAddr) && !OutEmpty;

    always_ff @(posedge Clk) begin
        if (reset) begin
            sBValid <= 1'b0;
            sBResp  <= scalerPkg::RespOkay;
            Gain    <= 16'h0100;  // Unity
            Offset  <= '0;
        end else if (writeFire) begin
            sBValid <= 1'b1;
            sBResp  <= wrMapped ? scalerPkg::RespOkay : scalerPkg::RespSlvErr;
            if (sAwAddr == scalerPkg::GainAddr) begin
                Gain <= sWData[15:0];
            end
            if (sAwAddr == scalerPkg::OffsetAddr) begin
                Offset <= sWData[SampleWidth-1:0];
            end
        end else if (sBReady) begin
            sBValid <= 1'b0;
        end
    end

    // Sticky error flags
    always_ff @(posedge Clk) begin
        if (reset || Clear) begin
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (writeFire && (sAwAddr == scalerPkg::DataInAddr) && InFull) begin
                overflow <= 1'b1;
            end
            if (readFire && (sArAddr == scalerPkg::DataOutAddr) && OutEmpty) begin
                underflow <= 1'b1;
            end
        end
    end

    always_comb begin
        status = '0;
        status[scalerPkg::StatusInEmpty]   = InEmpty;
        status[scalerPkg::StatusInFull]    = InFull;
        status[scalerPkg::StatusOutEmpty]  = OutEmpty;
        status[scalerPkg::StatusOutFull]   = OutFull;
        status[scalerPkg::StatusOverflow]  = overflow;
        status[scalerPkg::StatusUnderflow] = underflow;
        status[scalerPkg::StatusCountLsb +: FifoDepthLog2+1] = OutCount;
    end

    always_comb begin
        case (sArAddr)
            scalerPkg::GainAddr:   rdValue = {{(DataW-16){1'b0}}, Gain};
            scalerPkg::OffsetAddr: rdValue = {{ExtW{Offset[SampleWidth-1]}}, Offset};
            scalerPkg::StatusAddr: rdValue = status;
            default:               rdValue = '0;  // DATA_OUT comes from the FIFO instead
        endcase
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            sRValid    <= 1'b0;
            sRResp     <= scalerPkg::RespOkay;
            rdFromFifo <= 1'b0;
        end else if (readFire) begin
            sRValid    <= 1'b1;
            sRResp     <= rdMapped ? scalerPkg::RespOkay : scalerPkg::RespSlvErr;
            rdFromFifo <= OutPop;
        end else if (sRReady) begin
            sRValid <= 1'b0;
        end
    end

    always_ff @(posedge Clk) begin
        if (readFire) begin
            rdDataReg <= rdValue;
        end
    end

    // FIFO read data lands one cycle after the pop and stays until the next one
    assign sRData = rdFromFifo ? {{ExtW{OutPopData[SampleWidth-1]}}, OutPopData} : rdDataReg;

endmodule

/* design/scaleStage.sv */
`timescale 1ns/1ps

module scaleStage #(
    parameter int SampleWidth   = 16,
    parameter int FifoDepthLog2 = 4
) (
    input  logic                     Clk,
    input  logic                     reset,
    input  logic                     Clear,
    input  logic                     InEmpty,
    output logic                     InPop,
    input  logic [SampleWidth-1:0]   InPopData,
    input  logic [FifoDepthLog2:0]   OutCount,
    output logic                     OutPush,
    output logic [SampleWidth-1:0]   OutPushData,
    input  logic [15:0]              Gain,
    input  logic [SampleWidth-1:0]   Offset
);

    localparam int ProdWidth  = SampleWidth + 17;
    localparam int SumWidth   = ProdWidth + 1;
    localparam int CountWidth = FifoDepthLog2 + 2;
    localparam logic [CountWidth-1:0] Depth = CountWidth'(2 ** FifoDepthLog2);
    localparam logic signed [SumWidth-1:0] SatMax = SumWidth'((2 ** (SampleWidth - 1)) - 1);
    localparam logic signed [SumWidth-1:0] SatMin = SumWidth'(-(2 ** (SampleWidth - 1)));

    logic                         popPending;  // FIFO data arrives this cycle
    logic                         sumValid;
    logic [1:0]                   inFlight;
    logic [CountWidth-1:0]        occupied;
    logic signed [ProdWidth-1:0]  product;
    logic signed [ProdWidth-1:0]  scaled;
    logic signed [SumWidth-1:0]   sumNext;
    logic signed [SumWidth-1:0]   sumReg;

    // Reserve output space for everything already in the pipe
    assign inFlight = {1'b0, popPending} + {1'b0, sumValid};
    assign occupied = {1'b0, OutCount} + CountWidth'(inFlight);
    assign InPop    = !InEmpty && !Clear && (occupied < Depth);

    assign product = $signed(InPopData) * $signed({1'b0, Gain});
    assign scaled  = product >>> scalerPkg::GainFracBits;  // Floors toward minus infinity
    assign sumNext = scaled + $signed(Offset);

    always_ff @(posedge Clk) begin
        if (reset || Clear) begin
            popPending <= 1'b0;
            sumValid   <= 1'b0;
        end else begin
            popPending <= InPop;
            sumValid   <= popPending;
        end
    end

    always_ff @(posedge Clk) begin
        if (popPending) begin
            sumReg <= sumNext;
        end
    end

    always_comb begin
        if (sumReg > SatMax) begin
            OutPushData = SatMax[SampleWidth-1:0];
        end else if (sumReg < SatMin) begin
            OutPushData = SatMin[SampleWidth-1:0];
        end else begin
            OutPushData = sumReg[SampleWidth-1:0];
        end
    end

    assign OutPush = sumValid;

endmodule

/* design/sampleScalerTop.sv */
`timescale 1ns/1ps

module sampleScalerTop #(
    parameter int SampleWidth   = 16,
    parameter int FifoDepthLog2 = 4
) (
    input  logic                                  Clk,
    input  logic                                  reset,
    input  logic [scalerPkg::AddrWidth-1:0]       sAwAddr,
    input  logic                                  sAwValid,
    output logic                                  sAwReady,
    input  logic [scalerPkg::AxiDataWidth-1:0]    sWData,
    input  logic [scalerPkg::AxiDataWidth/8-1:0]  sWStrb,
    input  logic                                  sWValid,
    output logic                                  sWReady,
    output logic [1:0]                            sBResp,
    output logic                                  sBValid,
    input  logic                                  sBReady,
    input  logic [scalerPkg::AddrWidth-1:0]       sArAddr,
    input  logic                                  sArValid,
    output logic                                  sArReady,
    output logic [scalerPkg::AxiDataWidth-1:0]    sRData,
    output logic [1:0]                            sRResp,
    output logic                                  sRValid,
    input  logic                                  sRReady
);

    logic                     clear;
    logic [15:0]              gain;
    logic [SampleWidth-1:0]   offset;
    logic                     inPush;
    logic [SampleWidth-1:0]   inPushData;
    logic                     inPop;
    logic [SampleWidth-1:0]   inPopData;
    logic                     inFull;
    logic                     inEmpty;
    logic                     outPush;
    logic [SampleWidth-1:0]   outPushData;
    logic                     outPop;
    logic [SampleWidth-1:0]   outPopData;
    logic                     outFull;
    logic                     outEmpty;
    logic [FifoDepthLog2:0]   outCount;

    axiLiteRegs #(
        .SampleWidth  (SampleWidth),
        .FifoDepthLog2(FifoDepthLog2)
    ) i_regs (
        .Clk       (Clk),
        .reset     (reset),
        .sAwAddr   (sAwAddr),
        .sAwValid  (sAwValid),
        .sAwReady  (sAwReady),
        .sWData    (sWData),
        .sWStrb    (sWStrb),
        .sWValid   (sWValid),
        .sWReady   (sWReady),
        .sBResp    (sBResp),
        .sBValid   (sBValid),
        .sBReady   (sBReady),
        .sArAddr   (sArAddr),
        .sArValid  (sArValid),
        .sArReady  (sArReady),
        .sRData    (sRData),
        .sRResp    (sRResp),
        .sRValid   (sRValid),
        .sRReady   (sRReady),
        .Clear     (clear),
        .Gain      (gain),
        .Offset    (offset),
        .InPush    (inPush),
        .InPushData(inPushData),
        .InFull    (inFull),
        .InEmpty   (inEmpty),
        .OutPop    (outPop),
        .OutPopData(outPopData),
        .OutFull   (outFull),
        .OutEmpty  (outEmpty),
        .OutCount  (outCount)
    );

    sampleFifo #(
        .DataWidth(SampleWidth),
        .DepthLog2(FifoDepthLog2)
    ) i_inFifo (
        .Clk     (Clk),
        .reset   (reset),
        .Clear   (clear),
        .Push    (inPush),
        .PushData(inPushData),
        .Pop     (inPop),
        .PopData (inPopData),
        .Full    (inFull),
        .Empty   (inEmpty),
        .Count   ()  // Input occupancy is not reported
    );

    scaleStage #(
        .SampleWidth  (SampleWidth),
        .FifoDepthLog2(FifoDepthLog2)
    ) i_scale (
        .Clk        (Clk),
        .reset      (reset),
        .Clear      (clear),
        .InEmpty    (inEmpty),
        .InPop      (inPop),
        .InPopData  (inPopData),
        .OutCount   (outCount),
        .OutPush    (outPush),
        .OutPushData(outPushData),
        .Gain       (gain),
        .Offset     (offset)
    );

    sampleFifo #(
        .DataWidth(SampleWidth),
        .DepthLog2(FifoDepthLog2)
    ) i_outFifo (
        .Clk     (Clk),
        .reset   (reset),
        .Clear   (clear),
        .Push    (outPush),
        .PushData(outPushData),
        .Pop     (outPop),
        .PopData (outPopData),
        .Full    (outFull),
        .Empty   (outEmpty),
        .Count   (outCount)
    );

endmodule

/* sim/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
    parameter int HalfPeriod  = 20,  // 40 ns clock
    parameter int ResetCycles = 10
) (
    output logic Clk,
    output logic reset
);

    initial begin
        Clk = 1'b0;
        forever #(HalfPeriod) Clk = ~Clk;
    end

    // Reset drops on a falling edge like every other input
    initial begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge Clk);
        @(negedge Clk);
        reset = 1'b0;
    end

endmodule

/* sim/sampleScaler_assertions.sv */
`timescale 1ns/1ps

module sampleScaler_assertions (
    input logic Clk,
    input logic reset,
    input logic sBValid,
    input logic sBReady,
    input logic sRValid,
    input logic sRReady,
    input logic inPush,
    input logic inFull,
    input logic outPush,
    input logic outFull
);

    // Responses stay up until the master takes them
    bHeld: assert property (@(posedge Clk) disable iff (reset) sBValid && !sBReady |=> sBValid)
        else $error("write response dropped before bReady");

    rHeld: assert property (@(posedge Clk) disable iff (reset) sRValid && !sRReady |=> sRValid)
        else $error("read response dropped before rReady");

    outSafe: assert property (@(posedge Clk) disable iff (reset) !(outPush && outFull))
        else $error("output FIFO pushed while full");  // Back-pressure broken

    inSafe: assert property (@(posedge Clk) disable iff (reset) !(inPush && inFull))
        else $error("input FIFO pushed while full");

endmodule

bind sampleScalerTop sampleScaler_assertions i_checks (
    .Clk    (Clk),
    .reset  (reset),
    .sBValid(sBValid),
    .sBReady(sBReady),
    .sRValid(sRValid),
    .sRReady(sRReady),
    .inPush (inPush),
    .inFull (inFull),
    .outPush(outPush),
    .outFull(outFull)
);

/* sim/sampleScalerTb.sv */
`timescale 1ns/1ps

module sampleScalerTb;

    localparam int WaitLimit = 200;  // Cycles per handshake
    localparam int PollLimit = 50;   // STATUS reads per result
    localparam int NumRows   = 9;

    logic        Clk;
    logic        reset;
    logic [5:0]  awAddr;
    logic        awValid;
    logic        awReady;
    logic [31:0] wData;
    logic [3:0]  wStrb;
    logic        wValid;
    logic        wReady;
    logic [1:0]  bResp;
    logic        bValid;
    logic        bReady;
    logic [5:0]  arAddr;
    logic        arValid;
    logic        arReady;
    logic [31:0] rData;
    logic [1:0]  rResp;
    logic        rValid;
    logic        rReady;

    int errorCount;
    int testErrors;
    int testsPassed;
    int testsFailed;

    // Expected values are floored and clamped
    string rowName   [NumRows] = '{"unity", "halfGain", "halfGainNeg", "offsetOnly",
                                   "fracGain", "posSat", "negSat", "maxGain", "offsetSat"};
    int    rowGain   [NumRows] = '{'h100, 'h080, 'h080, 'h100, 'h180, 'h400, 'h400, 'hFFFF,
                                   'h100};
    int    rowOffset [NumRows] = '{0, 0, 0, -200, 10, 0, -100, 0, 32767};
    int    rowSample [NumRows] = '{1234, 1001, -1001, 50, -3, 20000, -9000, 1, 5};
    int    rowExpect [NumRows] = '{1234, 500, -501, -150, 5, 32767, -32768, 255, 32767};

    clockGen i_clk (
        .Clk  (Clk),
        .reset(reset)
    );

    sampleScalerTop i_dut (
        .Clk     (Clk),
        .reset   (reset),
        .sAwAddr (awAddr),
        .sAwValid(awValid),
        .sAwReady(awReady),
        .sWData  (wData),
        .sWStrb  (wStrb),
        .sWValid (wValid),
        .sWReady (wReady),
        .sBResp  (bResp),
        .sBValid (bValid),
        .sBReady (bReady),
        .sArAddr (arAddr),
        .sArValid(arValid),
        .sArReady(arReady),
        .sRData  (rData),
        .sRResp  (rResp),
        .sRValid (rValid),
        .sRReady (rReady)
    );

    function automatic int expectedScale(input int gain, input int offset, input int sample);
        longint product;
        longint floored;
        longint sum;
        product = longint'(sample) * longint'(gain);
        floored = product / 256;
        if (product < 0 && product % 256 != 0) begin
            floored = floored - 1;  // Round toward minus infinity
        end
        sum = floored + offset;
        if (sum > 32767) begin
            sum = 32767;
        end else if (sum < -32768) begin
            sum = -32768;
        end
        return int'(sum);
    endfunction

    // Called and returns on a falling edge
    task automatic writeRegister(input logic [5:0] addr, input logic [31:0] data,
                                 output logic [1:0] resp);
        int   cycles;
        logic accepted;
        cycles = 0;
        resp = 2'bxx;
        while (bValid && cycles < WaitLimit) begin  // Slave busy with the last response
            @(negedge Clk);
            cycles++;
        end
        awAddr  = addr;
        awValid = 1'b1;
        wData   = data;
        wValid  = 1'b1;
        cycles  = 0;
        do begin
            @(posedge Clk);
            accepted = awReady && wReady;
            cycles++;
        end while (!accepted && cycles < WaitLimit);
        @(negedge Clk);
        awValid = 1'b0;
        wValid  = 1'b0;
        if (!accepted) begin
            $display("TIMEOUT: write to address 0x%02h was never accepted", addr);
            errorCount++;
        end else begin
            cycles = 0;
            while (!bValid && cycles < WaitLimit) begin
                @(negedge Clk);
                cycles++;
            end
            if (!bValid) begin
                $display("TIMEOUT: no write response for address 0x%02h", addr);
                errorCount++;
            end else begin
                resp   = bResp;
                bReady = 1'b1;
                @(negedge Clk);
                bReady = 1'b0;
            end
        end
    endtask

    task automatic readRegister(input logic [5:0] addr, output logic [31:0] data,
                                output logic [1:0] resp);
        int cycles;
        cycles = 0;
        data = 'x;
        resp = 2'bxx;
        while (!arReady && cycles < WaitLimit) begin
            @(negedge Clk);
            cycles++;
        end
        arAddr  = addr;
        arValid = 1'b1;
        cycles  = 0;
        do begin
            @(negedge Clk);
            cycles++;
        end while (!rValid && cycles < WaitLimit);
        arValid = 1'b0;
        if (!rValid) begin
            $display("TIMEOUT: no read response for address 0x%02h", addr);
            errorCount++;
        end else begin
            data   = rData;
            resp   = rResp;
            rReady = 1'b1;
            @(negedge Clk);
            rReady = 1'b0;
        end
    endtask

    // Poll STATUS until the output FIFO holds a result
    task automatic waitForResult(input string name);
        logic [31:0] status;
        logic [1:0]  resp;
        int          polls;
        polls  = 0;
        status = '1;
        while (status[scalerPkg::StatusOutEmpty] && polls < PollLimit) begin
            readRegister(scalerPkg::StatusAddr, status, resp);
            polls++;
        end
        if (status[scalerPkg::StatusOutEmpty]) begin
            $display("TIMEOUT: no result reached the output FIFO in %s", name);
            errorCount++;
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic startTest();
        testErrors = errorCount;
    endtask

    task automatic finishTest(input string name);
        if (errorCount == testErrors) begin
            $display("test %-12s ok", name);
            testsPassed++;
        end else begin
            $display("test %-12s failed with %0d errors", name, errorCount - testErrors);
            testsFailed++;
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [1:0]  resp;
        logic [31:0] expStatus;
        int          gain;
        int          offset;
        int          cycles;
        int          samples [40];
        void'($urandom(93815));
        awAddr      = '0;
        awValid     = 1'b0;
        wData       = '0;
        wStrb       = 4'hF;
        wValid      = 1'b0;
        bReady      = 1'b0;
        arAddr      = '0;
        arValid     = 1'b0;
        rReady      = 1'b0;
        errorCount  = 0;
        testErrors  = 0;
        testsPassed = 0;
        testsFailed = 0;
        cycles      = 0;
        do begin
            @(negedge Clk);
            cycles++;
        end while (reset && cycles < 100);
        if (reset) begin
            $display("TIMEOUT: reset never released");
            errorCount++;
        end
        @(negedge Clk);

        startTest();
        readRegister(scalerPkg::GainAddr, rd, resp);
        checkWord("resetGain", 32'h100, rd);
        readRegister(scalerPkg::OffsetAddr, rd, resp);
        checkWord("resetOffset", 32'h0, rd);
        expStatus = (32'd1 << scalerPkg::StatusInEmpty) | (32'd1 << scalerPkg::StatusOutEmpty);
        readRegister(scalerPkg::StatusAddr, rd, resp);
        checkWord("resetStatus", expStatus, rd);
        writeRegister(scalerPkg::GainAddr, 32'h1234, resp);
        readRegister(scalerPkg::GainAddr, rd, resp);
        checkWord("gainReadback", 32'h1234, rd);
        writeRegister(scalerPkg::OffsetAddr, 32'hFFFF_8001, resp);
        readRegister(scalerPkg::OffsetAddr, rd, resp);
        checkWord("offsetReadback", 32'hFFFF_8001, rd);
        finishTest("registers");

        for (int i = 0; i < NumRows; i++) begin
            startTest();
            writeRegister(scalerPkg::GainAddr, rowGain[i], resp);
            writeRegister(scalerPkg::OffsetAddr, rowOffset[i], resp);
            writeRegister(scalerPkg::DataInAddr, rowSample[i], resp);
            waitForResult(rowName[i]);
            readRegister(scalerPkg::DataOutAddr, rd, resp);
            checkWord(rowName[i], 32'(rowExpect[i]), rd);
            finishTest(rowName[i]);
        end

        // Results must come back in write order under a random gain and offset
        startTest();
        gain   = int'($urandom_range(16'h300, 16'h040));
        offset = int'($urandom_range(2000)) - 1000;
        writeRegister(scalerPkg::GainAddr, gain, resp);
        writeRegister(scalerPkg::OffsetAddr, offset, resp);
        for (int i = 0; i < 8; i++) begin
            samples[i] = int'($urandom_range(65535)) - 32768;
            writeRegister(scalerPkg::DataInAddr, samples[i], resp);
        end
        for (int i = 0; i < 8; i++) begin
            waitForResult("ordering");
            readRegister(scalerPkg::DataOutAddr, rd, resp);
            checkWord($sformatf("order%0d", i), 32'(expectedScale(gain, offset, samples[i])), rd);
        end
        finishTest("ordering");

        startTest();
        writeRegister(scalerPkg::GainAddr, 32'h100, resp);
        writeRegister(scalerPkg::OffsetAddr, 32'h0, resp);
        for (int i = 0; i < 40; i++) begin
            samples[i] = i * 997 - 20000;
            writeRegister(scalerPkg::DataInAddr, samples[i], resp);
        end
        expStatus = (32'd1 << scalerPkg::StatusInFull) | (32'd1 << scalerPkg::StatusOutFull) |
                    (32'd1 << scalerPkg::StatusOverflow) | (32'd16 << scalerPkg::StatusCountLsb);
        readRegister(scalerPkg::StatusAddr, rd, resp);
        checkWord("fullStatus", expStatus, rd);
        for (int i = 0; i < 32; i++) begin
            waitForResult("backPressure");
            readRegister(scalerPkg::DataOutAddr, rd, resp);
            checkWord($sformatf("drain%0d", i), 32'(samples[i]), rd);
        end
        expStatus = (32'd1 << scalerPkg::StatusInEmpty) | (32'd1 << scalerPkg::StatusOutEmpty) |
                    (32'd1 << scalerPkg::StatusOverflow);
        readRegister(scalerPkg::StatusAddr, rd, resp);
        checkWord("drainedStatus", expStatus, rd);
        finishTest("backPressure");

        startTest();
        for (int i = 0; i < 5; i++) begin
            writeRegister(scalerPkg::DataInAddr, 32'(i + 1), resp);
        end
        writeRegister(scalerPkg::CtrlAddr, 32'h1, resp);
        expStatus = (32'd1 << scalerPkg::StatusInEmpty) | (32'd1 << scalerPkg::StatusOutEmpty);
        readRegister(scalerPkg::StatusAddr, rd, resp);
        checkWord("clearedStatus", expStatus, rd);
        readRegister(scalerPkg::DataOutAddr, rd, resp);
        checkWord("emptyRead", 32'h0, rd);
        checkWord("emptyReadResp", 32'(scalerPkg::RespOkay), 32'(resp));
        expStatus = expStatus | (32'd1 << scalerPkg::StatusUnderflow);
        readRegister(scalerPkg::StatusAddr, rd, resp);
        checkWord("underflowStatus", expStatus, rd);
        finishTest("clear");

        startTest();
        writeRegister(6'h18, 32'hFFFF_FFFF, resp);
        checkWord("badWriteResp", 32'(scalerPkg::RespSlvErr), 32'(resp));
        readRegister(6'h18, rd, resp);
        checkWord("badReadResp", 32'(scalerPkg::RespSlvErr), 32'(resp));
        readRegister(scalerPkg::GainAddr, rd, resp);
        checkWord("gainKept", 32'h100, rd);
        readRegister(scalerPkg::OffsetAddr, rd, resp);
        checkWord("offsetKept", 32'h0, rd);
        finishTest("unmapped");

        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 testsPassed, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
design/scalerPkg.sv
design/sampleFifo.sv
design/axiLiteRegs.sv
design/scaleStage.sv
design/sampleScalerTop.sv
sim/clockGen.sv
sim/sampleScaler_assertions.sv
sim/sampleScalerTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module sampleScalerTb \
    -f project.f -o simv \
    && ./obj_dir/simv | tee sim.log \
    || { echo "Build or simulation failed"; exit 1; }

grep -qx "STATUS: PASS" sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
